// ==== src/exe_defs.svh ====
`ifndef EXE_DEFS_SVH
`define EXE_DEFS_SVH

// data word width
`define XLEN 32

// register file address width
`define REG_AW 5

// operation code widths
`define ALU_FNW 4
`define MD_OPW 3
`define WB_SELW 3
`define MEM_OPW 4

`endif

// ==== src/exeOpsPkg.sv ====
`include "exe_defs.svh"

package exeOpsPkg;

	typedef logic [`XLEN-1:0] wordT;
	typedef logic [`REG_AW-1:0] regAddrT;

	// integer ALU functions
	typedef enum logic [`ALU_FNW-1:0] {
		ADD,
		SUB,
		SLL,
		SLT,
		SLTU,
		XOR,
		SRL,
		SRA,
		OR,
		AND
	} aluFnT;

	// RV32M operations
	typedef enum logic [`MD_OPW-1:0] {
		MUL, MULH, MULHSU, MULHU,
		DIV, DIVU, REM, REMU
	} mulDivOpT;

	// write-back source, LOAD is left to the memory stage
	typedef enum logic [`WB_SELW-1:0] {
		ALU    = 3'd0,
		LINK   = 3'd1,
		MULDIV = 3'd2,
		LUI    = 3'd3,
		LOAD   = 3'd4,
		AUIPC  = 3'd5
	} wbSelT;

endpackage

// ==== src/memOpsPkg.sv ====
`include "exe_defs.svh"

package memOpsPkg;

	// data memory operations, loads then stores
	typedef enum logic [`MEM_OPW-1:0] {
		NONE,
		LB,
		LH,
		LW,
		LBU,
		LHU,
		SB,
		SH,
		SW
	} memOpT;

	// one enable per byte lane
	typedef logic [`XLEN/8-1:0] byteEnT;

endpackage

// ==== src/alu.sv ====
`timescale 1ns/1ps

module alu (
	input exeOpsPkg::aluFnT aluFn,
	input exeOpsPkg::wordT opA,
	input exeOpsPkg::wordT opB,
	input logic btype,
	input logic bneq,
	output exeOpsPkg::wordT result,
	output logic taken
);

	import exeOpsPkg::*;

	logic [4:0] shamt;
	logic isZero;

	assign shamt = opB[4:0];	// RV32 shifts use 5 bits

	always_comb
	begin
		case (aluFn)
			ADD:
				result = opA + opB;
			SUB:
				result = opA - opB;
			SLL:
				result = opA << shamt;
			SLT:
				result = wordT'($signed(opA) < $signed(opB));
			SLTU:
				result = wordT'(opA < opB);
			XOR:
				result = opA ^ opB;
			SRL:
				result = opA >> shamt;
			SRA:
				result = wordT'($signed(opA) >>> shamt);	// keeps sign
			OR:
				result = opA | opB;
			AND:
				result = opA & opB;
			default:
				result = '0;
		endcase
	end

	// beq/bge/bgeu want zero, bne/blt/bltu want nonzero
	assign isZero = (result == '0);
	assign taken = btype & (isZero != bneq);

endmodule

// ==== src/branchUnit.sv ====
`timescale 1ns/1ps

module branchUnit (
	input exeOpsPkg::wordT pc,
	input exeOpsPkg::wordT opA,
	input exeOpsPkg::wordT opB,	// I-immediate for jalr
	input exeOpsPkg::wordT bImm,
	input exeOpsPkg::wordT jImm,
	input logic taken,
	input logic j,
	input logic jr,
	output exeOpsPkg::wordT target,
	output logic bjTaken
);

	import exeOpsPkg::*;

	wordT addA;
	wordT addB;
	wordT sum;

	// pick adder inputs by jump kind
	always_comb
	begin
		if (j)
		begin
			addA = pc;
			addB = jImm;
		end
		else if (jr)
		begin
			addA = opA;	// jalr base register
			addB = opB;
		end
		else
		begin
			addA = pc;
			addB = bImm;
		end
	end

	assign sum = addA + addB;
	assign target = {sum[$high(sum):1], sum[0] & ~jr};	// jalr clears lsb
	assign bjTaken = taken | j | jr;

endmodule

// ==== src/mulDiv.sv ====
`timescale 1ns/1ps
`include "exe_defs.svh"

module mulDiv (
	input exeOpsPkg::mulDivOpT op,
	input exeOpsPkg::wordT a,
	input exeOpsPkg::wordT b,
	output exeOpsPkg::wordT res
);

	import exeOpsPkg::*;

	localparam wordT MOST_NEG = {1'b1, {(`XLEN-1){1'b0}}};

	logic aSigned;
	logic bSigned;
	logic signed [`XLEN:0] aExt;
	logic signed [`XLEN:0] bExt;
	logic signed [2*`XLEN+1:0] prodFull;
	logic [2*`XLEN-1:0] prod;
	logic divZero;
	logic overflow;
	wordT bSafe;
	wordT sQuot;
	wordT sRem;
	wordT uQuot;
	wordT uRem;

	// mulhsu treats only a as signed
	assign aSigned = (op == MULH) || (op == MULHSU);
	assign bSigned = (op == MULH);
	assign aExt = {aSigned & a[`XLEN-1], a};
	assign bExt = {bSigned & b[`XLEN-1], b};
	assign prodFull = aExt * bExt;
	assign prod = prodFull[2*`XLEN-1:0];

	assign divZero = (b == '0);
	assign overflow = (a == MOST_NEG) && (b == '1);	// -2^31 / -1
	assign bSafe = divZero ? wordT'(1) : b;	// keeps the dividers defined

	assign sQuot = wordT'($signed(a) / $signed(bSafe));
	assign sRem = wordT'($signed(a) % $signed(bSafe));
	assign uQuot = a / bSafe;
	assign uRem = a % bSafe;

	always_comb
	begin
		case (op)
			MUL:
				res = prod[`XLEN-1:0];
			MULH, MULHSU, MULHU:
				res = prod[2*`XLEN-1:`XLEN];
			DIV:
				res = divZero ? '1 : (overflow ? a : sQuot);
			DIVU:
				res = divZero ? '1 : uQuot;
			REM:
				res = divZero ? a : (overflow ? '0 : sRem);
			REMU:
				res = divZero ? a : uRem;
			default:
				res = '0;
		endcase
	end

endmodule

// ==== src/memInterface.sv ====
`timescale 1ns/1ps
`include "exe_defs.svh"

module memInterface (
	input logic clk,
	input logic nrst,
	input memOpsPkg::memOpT memOp,
	input exeOpsPkg::wordT opA,	// base address
	input exeOpsPkg::wordT opB,	// store source, load offset
	input exeOpsPkg::wordT sImm,	// store offset
	output exeOpsPkg::wordT addr6,
	output exeOpsPkg::wordT storeData6,
	output memOpsPkg::byteEnT byteEn6,
	output logic memWe6,
	output logic memRd6,
	output logic memAccess6,
	output logic misaligned6,
	output logic ldMisaligned6,
	output logic stMisaligned6
);

	import memOpsPkg::*;

	memOpT memOp5;
	logic [`XLEN-1:0] base5;
	logic [`XLEN-1:0] offset5;
	logic [`XLEN-1:0] src5;
	logic [`XLEN-1:0] addr5;
	logic [`XLEN-1:0] data5;
	byteEnT sizeMask;
	byteEnT lanes5;
	logic isLoad;
	logic isStore;
	logic isByte;
	logic isHalf;
	logic mis5;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			memOp5 <= NONE;
			base5 <= '0;
			offset5 <= '0;
			src5 <= '0;
		end
		else
		begin
			memOp5 <= memOp;
			base5 <= opA;
			offset5 <= (memOp inside {SB, SH, SW}) ? sImm : opB;	// S vs I immediate
			src5 <= opB;
		end
	end

	// size and direction
	assign isLoad = memOp5 inside {LB, LH, LW, LBU, LHU};
	assign isStore = memOp5 inside {SB, SH, SW};
	assign isByte = memOp5 inside {LB, LBU, SB};
	assign isHalf = memOp5 inside {LH, LHU, SH};

	assign addr5 = base5 + offset5;
	assign sizeMask = isByte ? 4'b0001 : (isHalf ? 4'b0011 : 4'b1111);
	assign mis5 = (isLoad | isStore) &&
		((isHalf && addr5[0]) || (!isByte && !isHalf && addr5[1:0] != 2'b00));
	assign lanes5 = mis5 ? '0 : (sizeMask << addr5[1:0]);	// enables only if aligned

	// replicate low bytes into every lane
	assign data5 = isByte ? {4{src5[7:0]}} : (isHalf ? {2{src5[15:0]}} : src5);

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			addr6 <= '0;
			storeData6 <= '0;
			byteEn6 <= '0;
			memWe6 <= 1'b0;
			memRd6 <= 1'b0;
			memAccess6 <= 1'b0;
			misaligned6 <= 1'b0;
			ldMisaligned6 <= 1'b0;
			stMisaligned6 <= 1'b0;
		end
		else
		begin
			addr6 <= addr5;
			storeData6 <= data5;
			byteEn6 <= (isLoad | isStore) ? lanes5 : '0;
			memWe6 <= isStore & ~mis5;
			memRd6 <= isLoad & ~mis5;
			memAccess6 <= isLoad | isStore;
			misaligned6 <= mis5;
			ldMisaligned6 <= mis5 & isLoad;
			stMisaligned6 <= mis5 & isStore;
		end
	end

endmodule

// ==== src/exeStage.sv ====
`timescale 1ns/1ps

module exeStage (
	input logic clk,
	input logic nrst,
	input exeOpsPkg::wordT opA,
	input exeOpsPkg::wordT opB,
	input exeOpsPkg::regAddrT rd4,
	input logic we4,
	input exeOpsPkg::wbSelT wbSel4,
	input exeOpsPkg::aluFnT aluFn4,
	input exeOpsPkg::mulDivOpT mulDivOp4,
	input exeOpsPkg::wordT bImm4,
	input exeOpsPkg::wordT jImm4,
	input exeOpsPkg::wordT uImm4,
	input exeOpsPkg::wordT sImm4,
	input logic btype4,
	input logic bneq4,
	input logic j4,
	input logic jr4,
	input memOpsPkg::memOpT memOp4,
	input exeOpsPkg::wordT pc4,
	output exeOpsPkg::wordT wbData6,
	output logic we6,
	output exeOpsPkg::regAddrT rd6,
	output exeOpsPkg::wordT uImm6,
	output exeOpsPkg::wordT auImm6,
	output exeOpsPkg::wordT mulDivRes6,
	output exeOpsPkg::wordT target6,
	output logic bjTaken6,
	output exeOpsPkg::wordT pc6,
	output exeOpsPkg::wordT memAddr6,
	output exeOpsPkg::wordT storeData6,
	output memOpsPkg::byteEnT byteEn6,
	output logic memWe6,
	output logic memRd6,
	output logic memAccess6,
	output logic misaligned6,
	output logic ldMisaligned6,
	output logic stMisaligned6
);

	import exeOpsPkg::*;

	wordT opA5, opB5, bImm5, jImm5, uImm5, pc5;
	regAddrT rd5;
	logic we5, btype5, bneq5, j5, jr5;
	wbSelT wbSel5, wbSel6;
	aluFnT aluFn5;
	mulDivOpT mulDivOp5;
	wordT aluRes5, mulDivRes5, target5;
	logic taken5, bjTaken5;
	wordT aluRes6, link6;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			opA5 <= '0;
			opB5 <= '0;
			rd5 <= '0;
			we5 <= 1'b0;
			wbSel5 <= ALU;
			aluFn5 <= ADD;
			mulDivOp5 <= MUL;
			bImm5 <= '0;
			jImm5 <= '0;
			uImm5 <= '0;
			btype5 <= 1'b0;
			bneq5 <= 1'b0;
			j5 <= 1'b0;
			jr5 <= 1'b0;
			pc5 <= '0;
		end
		else
		begin
			opA5 <= opA;
			opB5 <= opB;
			rd5 <= rd4;
			we5 <= we4;
			wbSel5 <= wbSel4;
			aluFn5 <= aluFn4;
			mulDivOp5 <= mulDivOp4;
			bImm5 <= bImm4;
			jImm5 <= jImm4;
			uImm5 <= uImm4;
			btype5 <= btype4;
			bneq5 <= bneq4;
			j5 <= j4;
			jr5 <= jr4;
			pc5 <= pc4;
		end
	end

	alu u_alu (.aluFn(aluFn5), .opA(opA5), .opB(opB5), .btype(btype5), .bneq(bneq5),
		.result(aluRes5), .taken(taken5));

	branchUnit u_branch (.pc(pc5), .opA(opA5), .opB(opB5), .bImm(bImm5), .jImm(jImm5),
		.taken(taken5), .j(j5), .jr(jr5), .target(target5), .bjTaken(bjTaken5));

	mulDiv u_mulDiv (.op(mulDivOp5), .a(opA5), .b(opB5), .res(mulDivRes5));

	// memory path keeps its own stage 5 and 6 registers
	memInterface u_mem (.clk(clk), .nrst(nrst), .memOp(memOp4), .opA(opA), .opB(opB),
		.sImm(sImm4), .addr6(memAddr6), .storeData6(storeData6), .byteEn6(byteEn6),
		.memWe6(memWe6), .memRd6(memRd6), .memAccess6(memAccess6),
		.misaligned6(misaligned6), .ldMisaligned6(ldMisaligned6),
		.stMisaligned6(stMisaligned6));

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			wbSel6 <= ALU;
			aluRes6 <= '0;
			link6 <= '0;
			we6 <= 1'b0;
			rd6 <= '0;
			uImm6 <= '0;
			auImm6 <= '0;
			mulDivRes6 <= '0;
			target6 <= '0;
			bjTaken6 <= 1'b0;
			pc6 <= '0;
		end
		else
		begin
			wbSel6 <= wbSel5;
			aluRes6 <= aluRes5;
			link6 <= pc5 + wordT'(4);	// return address
			we6 <= we5;
			rd6 <= rd5;
			uImm6 <= uImm5;
			auImm6 <= uImm5 + pc5;	// auipc sum
			mulDivRes6 <= mulDivRes5;
			target6 <= target5;
			bjTaken6 <= bjTaken5;
			pc6 <= pc5;
		end
	end

	// load data is selected in a later stage
	always_comb
	begin
		case (wbSel6)
			ALU:
				wbData6 = aluRes6;
			LINK:
				wbData6 = link6;
			MULDIV:
				wbData6 = mulDivRes6;
			LUI:
				wbData6 = uImm6;
			AUIPC:
				wbData6 = auImm6;
			default:
				wbData6 = '0;
		endcase
	end

endmodule

// ==== verif/exeStageTb.sv ====
`timescale 1ns/1ps

module exeStageTb;

	import exeOpsPkg::*;
	import memOpsPkg::*;

	localparam int RANDOM_COUNT = 420;
	localparam int MAX_CYCLES = 600;	// ~515 cycles of stimulus plus margin

	// expected stage-6 outputs of one instruction
	typedef struct packed {
		wordT wbData;
		logic we;
		regAddrT rd;
		wordT uImm;
		wordT auImm;
		wordT mulDivRes;
		wordT target;
		logic bjTaken;
		wordT pc;
		wordT addr;
		wordT storeData;
		byteEnT byteEn;
		logic memWe;
		logic memRd;
		logic memAccess;
		logic mis;
		logic ldMis;
		logic stMis;
	} outputsT;

	logic clk;
	logic nrst;
	wordT opA, opB, bImm4, jImm4, uImm4, sImm4, pc4;
	regAddrT rd4;
	logic we4, btype4, bneq4, j4, jr4;
	wbSelT wbSel4;
	aluFnT aluFn4;
	mulDivOpT mulDivOp4;
	memOpT memOp4;

	wordT wbData6, uImm6, auImm6, mulDivRes6, target6, pc6, memAddr6, storeData6;
	regAddrT rd6;
	byteEnT byteEn6;
	logic we6, bjTaken6, memWe6, memRd6, memAccess6;
	logic misaligned6, ldMisaligned6, stMisaligned6;

	outputsT want5;
	outputsT want6;
	logic [31:0] seed = 32'd20;
	logic armed = 1'b0;
	int cycles = 0;
	int errors = 0;

	exeStage DUT (.*);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] nextRandom();
		seed = seed * 32'd1664525 + 32'd1013904223;	// LCG step
		return seed;
	endfunction

	task automatic stopRun(input string why);
		errors++;
		$display("%s", why);
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic valueError(input string name, input logic [63:0] got,
		input logic [63:0] want);
		stopRun($sformatf("Mismatch at %0t: %s is %0h, expected %0h", $time, name, got, want));
	endtask

	function automatic wordT aluModel(aluFnT fn, wordT a, wordT b);
		case (fn)
			ADD:
				return a + b;
			SUB:
				return a - b;
			SLL:
				return a << b[4:0];
			SLT:
				return {31'b0, $signed(a) < $signed(b)};
			SLTU:
				return {31'b0, a < b};
			XOR:
				return a ^ b;
			SRL:
				return a >> b[4:0];
			SRA:
				return wordT'($signed(a) >>> b[4:0]);
			OR:
				return a | b;
			AND:
				return a & b;
			default:
				return '0;
		endcase
	endfunction

	function automatic wordT mulDivModel(mulDivOpT op, wordT a, wordT b);
		longint sa;
		longint sb;
		logic [63:0] p;
		logic divZero;
		logic ovf;
		wordT sQuot;
		wordT sRem;
		wordT uQuot;
		wordT uRem;
		sa = longint'($signed(a));
		sb = longint'($signed(b));
		p = sa * sb;
		if (op == MULHSU)
			p = sa * longint'({32'b0, b});
		else if (op == MULHU)
			p = {32'b0, a} * {32'b0, b};
		divZero = (b == '0);
		ovf = (a == 32'h8000_0000) && (b == 32'hFFFF_FFFF);
		sQuot = '1;	// divide by zero results
		sRem = a;
		uQuot = '1;
		uRem = a;
		if (ovf)
		begin
			sQuot = a;
			sRem = '0;
		end
		else if (!divZero)
		begin
			sQuot = $signed(a) / $signed(b);
			sRem = $signed(a) % $signed(b);
		end
		if (!divZero)
		begin
			uQuot = a / b;
			uRem = a % b;
		end
		case (op)
			MUL:
				return p[31:0];
			DIV:
				return sQuot;
			DIVU:
				return uQuot;
			REM:
				return sRem;
			REMU:
				return uRem;
			default:
				return p[63:32];	// the three high-half products
		endcase
	endfunction

	// expected outputs for the instruction now on the stage-4 inputs
	function automatic outputsT predict();
		outputsT e;
		wordT aluVal;
		logic taken;
		logic isLd;
		logic isSt;
		int bytes;
		byteEnT lanes;
		e = '0;
		aluVal = aluModel(aluFn4, opA, opB);
		taken = btype4 && ((aluVal == '0) != bneq4);
		e.bjTaken = taken || j4 || jr4;
		if (j4)
			e.target = pc4 + jImm4;
		else if (jr4)
			e.target = (opA + opB) & 32'hFFFF_FFFE;
		else
			e.target = pc4 + bImm4;
		e.we = we4;
		e.rd = rd4;
		e.uImm = uImm4;
		e.auImm = uImm4 + pc4;
		e.pc = pc4;
		e.mulDivRes = mulDivModel(mulDivOp4, opA, opB);
		case (wbSel4)
			ALU:
				e.wbData = aluVal;
			LINK:
				e.wbData = pc4 + 32'd4;
			MULDIV:
				e.wbData = e.mulDivRes;
			LUI:
				e.wbData = uImm4;
			AUIPC:
				e.wbData = uImm4 + pc4;
			default:
				e.wbData = '0;	// reserved load and unknown codes
		endcase

		isLd = memOp4 inside {LB, LH, LW, LBU, LHU};
		isSt = memOp4 inside {SB, SH, SW};
		bytes = (memOp4 inside {LB, LBU, SB}) ? 1 : ((memOp4 inside {LH, LHU, SH}) ? 2 : 4);
		e.addr = opA + (isSt ? sImm4 : opB);
		e.mis = (isLd || isSt) &&
			((bytes == 2 && e.addr[0]) || (bytes == 4 && e.addr[1:0] != 2'b00));
		lanes = 4'((1 << bytes) - 1);
		e.byteEn = (e.mis || !(isLd || isSt)) ? '0 : byteEnT'(lanes << e.addr[1:0]);
		if (bytes == 1)
			e.storeData = {4{opB[7:0]}};
		else if (bytes == 2)
			e.storeData = {2{opB[15:0]}};
		else
			e.storeData = opB;
		e.memWe = isSt && !e.mis;
		e.memRd = isLd && !e.mis;
		e.memAccess = isLd || isSt;
		e.ldMis = e.mis && isLd;
		e.stMis = e.mis && isSt;
		return e;
	endfunction

	// two-deep model pipeline, same latency as the stage
	always @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			want5 <= '0;
			want6 <= '0;
		end
		else
		begin
			want5 <= predict();
			want6 <= want5;
		end
	end

	always @(posedge clk)
	begin
		armed <= 1'b1;	// skip the edge before any reset
		cycles <= cycles + 1;
		if (cycles == MAX_CYCLES)
			stopRun($sformatf("timeout: run still going after %0d cycles", MAX_CYCLES));
	end

	assert property (@(posedge clk) !armed || nrst || (wbData6 == '0 && !we6 && !memWe6
		&& !memRd6 && !bjTaken6 && !misaligned6 && !ldMisaligned6 && !stMisaligned6))
		else stopRun($sformatf("outputs not cleared while in reset at %0t", $time));
	assert property (@(posedge clk) !armed || wbData6 == want6.wbData)
		else valueError("wbData6", $sampled(wbData6), $sampled(want6.wbData));
	assert property (@(posedge clk) !armed || {we6, rd6} == {want6.we, want6.rd})
		else valueError("we6/rd6", $sampled({we6, rd6}), $sampled({want6.we, want6.rd}));
	assert property (@(posedge clk) !armed || {uImm6, auImm6} == {want6.uImm, want6.auImm})
		else valueError("uImm6/auImm6", $sampled({uImm6, auImm6}),
			$sampled({want6.uImm, want6.auImm}));
	assert property (@(posedge clk) !armed || mulDivRes6 == want6.mulDivRes)
		else valueError("mulDivRes6", $sampled(mulDivRes6), $sampled(want6.mulDivRes));
	assert property (@(posedge clk) !armed || {bjTaken6, target6} == {want6.bjTaken, want6.target})
		else valueError("bjTaken6/target6", $sampled({bjTaken6, target6}),
			$sampled({want6.bjTaken, want6.target}));
	assert property (@(posedge clk) !armed || pc6 == want6.pc)
		else valueError("pc6", $sampled(pc6), $sampled(want6.pc));
	assert property (@(posedge clk) !armed || memAddr6 == want6.addr)
		else valueError("memAddr6", $sampled(memAddr6), $sampled(want6.addr));
	assert property (@(posedge clk) !armed || storeData6 == want6.storeData)
		else valueError("storeData6", $sampled(storeData6), $sampled(want6.storeData));
	assert property (@(posedge clk) !armed || {memWe6, memRd6, memAccess6, byteEn6} ==
		{want6.memWe, want6.memRd, want6.memAccess, want6.byteEn})
		else valueError("memWe6/memRd6/memAccess6/byteEn6",
			$sampled({memWe6, memRd6, memAccess6, byteEn6}),
			$sampled({want6.memWe, want6.memRd, want6.memAccess, want6.byteEn}));
	assert property (@(posedge clk) !armed || {misaligned6, ldMisaligned6, stMisaligned6} ==
		{want6.mis, want6.ldMis, want6.stMis})
		else valueError("misaligned flags", $sampled({misaligned6, ldMisaligned6, stMisaligned6}),
			$sampled({want6.mis, want6.ldMis, want6.stMis}));

	// random instruction, mostly no jumps
	task automatic randomFields();
		opA <= nextRandom();
		opB <= nextRandom();
		rd4 <= regAddrT'(nextRandom() >> 27);
		we4 <= 1'(nextRandom() >> 31);
		wbSel4 <= wbSelT'(3'(nextRandom() >> 29));	// reserved and unknown codes too
		aluFn4 <= aluFnT'(4'((nextRandom() >> 16) % 10));
		mulDivOp4 <= mulDivOpT'(3'(nextRandom() >> 29));
		bImm4 <= nextRandom() & 32'hFFFF_FFFE;
		jImm4 <= nextRandom() & 32'hFFFF_FFFE;
		uImm4 <= nextRandom() & 32'hFFFF_F000;
		sImm4 <= nextRandom();
		btype4 <= 1'(nextRandom() >> 31);
		bneq4 <= 1'(nextRandom() >> 31);
		j4 <= (nextRandom() >> 29) == 0;
		jr4 <= (nextRandom() >> 29) == 0;
		memOp4 <= memOpT'(4'((nextRandom() >> 16) % 9));
		pc4 <= nextRandom() & 32'hFFFF_FFFC;
	endtask

	// divide by zero, overflow and a plain negative case for every op
	task automatic divideTests();
		wordT as[3];
		wordT bs[3];
		as = '{32'h1234_5678, 32'h8000_0000, 32'hFFFF_FFF9};
		bs = '{32'h0, 32'hFFFF_FFFF, 32'h2};
		for (int k = 0; k < 8; k++)
			for (int p = 0; p < 3; p++)
			begin
				@(posedge clk);
				randomFields();
				mulDivOp4 <= mulDivOpT'(3'(k));
				wbSel4 <= MULDIV;
				opA <= as[p];
				opB <= bs[p];
			end
	endtask

	task automatic branchTests();
		aluFnT fns[6];
		logic neqs[6];
		wordT as[3];
		wordT bs[3];
		fns = '{SUB, SUB, SLT, SLT, SLTU, SLTU};	// beq bne blt bge bltu bgeu
		neqs = '{1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0};
		as = '{32'd7, 32'hFFFF_FFF0, 32'd3};
		bs = '{32'd7, 32'd3, 32'hFFFF_FFF0};
		for (int c = 0; c < 6; c++)
			for (int p = 0; p < 3; p++)
			begin
				@(posedge clk);
				randomFields();
				aluFn4 <= fns[c];
				btype4 <= 1'b1;
				bneq4 <= neqs[c];
				j4 <= 1'b0;
				jr4 <= 1'b0;
				opA <= as[p];
				opB <= bs[p];
			end
		@(posedge clk);
		randomFields();
		j4 <= 1'b1;
		wbSel4 <= LINK;
		@(posedge clk);
		randomFields();
		j4 <= 1'b0;
		jr4 <= 1'b1;
		opA <= 32'h0000_2000;
		opB <= 32'h0000_0035;	// odd sum
		wbSel4 <= LINK;
	endtask

	// every size and direction at every byte offset
	task automatic memoryTests();
		memOpT ops[8];
		wordT base;
		ops = '{LB, LH, LW, LBU, LHU, SB, SH, SW};
		for (int k = 0; k < 8; k++)
			for (int off = 0; off < 4; off++)
			begin
				base = nextRandom() & 32'hFFFF_FFFC;
				@(posedge clk);
				randomFields();
				memOp4 <= ops[k];
				opA <= base;
				sImm4 <= wordT'(off);
				if (!(ops[k] inside {SB, SH, SW}))
					opB <= wordT'(off);	// loads take the offset from opB
			end
	endtask

	initial
	begin
		nrst = 1'b0;
		opA = '0;
		opB = '0;
		rd4 = '0;
		we4 = 1'b0;
		wbSel4 = ALU;
		aluFn4 = ADD;
		mulDivOp4 = MUL;
		bImm4 = '0;
		jImm4 = '0;
		uImm4 = '0;
		sImm4 = '0;
		btype4 = 1'b0;
		bneq4 = 1'b0;
		j4 = 1'b0;
		jr4 = 1'b0;
		memOp4 = NONE;
		pc4 = '0;
		repeat (5) @(posedge clk);
		nrst <= 1'b1;
		for (int s = 0; s < 8; s++)
		begin
			@(posedge clk);
			randomFields();
			wbSel4 <= wbSelT'(3'(s));
		end
		divideTests();
		branchTests();
		memoryTests();
		for (int n = 0; n < RANDOM_COUNT; n++)
		begin
			@(posedge clk);
			randomFields();
		end
		repeat (3) @(posedge clk);	// drain the pipeline
		@(negedge clk);
		if (errors == 0)
		begin
			$display("STATUS: PASS");
			$finish;
		end
		else
			stopRun("checks failed during the run");
	end

endmodule

// ==== tb.f ====
+incdir+src
src/exeOpsPkg.sv
src/memOpsPkg.sv
src/alu.sv
src/branchUnit.sv
src/mulDiv.sv
src/memInterface.sv
src/exeStage.sv
verif/exeStageTb.sv

// ==== Makefile ====
SRCS := $(wildcard src/*.sv src/*.svh verif/*.sv)

.PHONY: all run clean

all: run

obj_dir/VexeStageTb: tb.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module exeStageTb -f tb.f

run: obj_dir/VexeStageTb
	./obj_dir/VexeStageTb | tee sim.log
	grep -q "^STATUS: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log
